//--- compile.f
hdl/back_end_pkg.sv
hdl/bypass_controller.sv
hdl/execution_unit.sv
hdl/commit_stage.sv
hdl/reorder_buffer.sv
hdl/back_end.sv
testbench/back_end_tb.sv

//--- hdl/back_end.sv
`timescale 1ns/100ps

module back_end
    import back_end_pkg::*;
(
    input logic clk_i,
    input logic rst_n_i,

    input logic issue_valid_i,
    input issue_t issue_i,

    output logic stall_o,
    output logic pipeline_empty_o,

    output logic writeback_o,
    output reg_addr_t reg_destination_o,
    output data_word_t writeback_result_o
);

    data_word_t [1:0] forwarded_operand;

    exu_result_t [EXU_PORT - 1:0] exec_result, commit_buffer;
    logic exec_busy;

    logic commit_full, commit_empty, rob_full, rob_empty;

    // ==================================================
    // Bypass stage
    // ==================================================

    bypass_controller bypass (
        .issue_i         ( issue_i           ),
        .exec_result_i   ( exec_result       ),
        .commit_result_i ( commit_buffer     ),
        .operand_o       ( forwarded_operand )
    );

    logic bypass_valid;
    exu_op_t bypass_op;
    data_word_t [1:0] bypass_operand;
    instr_packet_t bypass_ipacket;

    // Upstream holds its bundle while stalled so nothing is lost here
    always_ff @(posedge clk_i) begin : bypass_stage_register
        if (!rst_n_i) begin
            bypass_valid <= 1'b0;
        end else if (!stall_o) begin
            bypass_valid <= issue_valid_i;
            bypass_op <= issue_i.op;
            bypass_operand <= forwarded_operand;
            bypass_ipacket <= issue_i.ipacket;
        end
    end : bypass_stage_register

    // ==================================================
    // Execute and commit
    // ==================================================

    // A bypass instruction held by the stall enters execute only once
    // Execute and commit pause together when the commit buffers are full
    execution_unit execute (
        .clk_i     ( clk_i                    ),
        .rst_n_i   ( rst_n_i                  ),
        .stall_i   ( commit_full              ),
        .valid_i   ( bypass_valid & !stall_o  ),
        .op_i      ( bypass_op                ),
        .operand_i ( bypass_operand           ),
        .ipacket_i ( bypass_ipacket           ),
        .result_o  ( exec_result              ),
        .busy_o    ( exec_busy                )
    );

    logic rob_write;
    rob_tag_t rob_tag;
    rob_entry_t rob_entry;

    commit_stage commit (
        .clk_i       ( clk_i         ),
        .rst_n_i     ( rst_n_i       ),
        .stall_i     ( commit_full   ),
        .result_i    ( exec_result   ),
        .full_o      ( commit_full   ),
        .buffer_o    ( commit_buffer ),
        .rob_write_o ( rob_write     ),
        .rob_tag_o   ( rob_tag       ),
        .rob_entry_o ( rob_entry     ),
        .empty_o     ( commit_empty  )
    );

    // Keeps moving under stall
    // The commit buffers drain through it to clear the stall
    logic rob_stage_write;
    rob_tag_t rob_stage_tag;
    rob_entry_t rob_stage_entry;

    always_ff @(posedge clk_i) begin : rob_stage_register
        if (!rst_n_i) begin
            rob_stage_write <= 1'b0;
        end else begin
            rob_stage_write <= rob_write;
            rob_stage_tag <= rob_tag;
            rob_stage_entry <= rob_entry;
        end
    end : rob_stage_register

    // ==================================================
    // Reorder buffer and writeback
    // ==================================================

    logic head_valid;
    rob_entry_t head_entry;

    reorder_buffer rob (
        .clk_i   ( clk_i           ),
        .rst_n_i ( rst_n_i         ),
        .stall_i ( commit_full     ),
        .write_i ( rob_stage_write ),
        .tag_i   ( rob_stage_tag   ),
        .entry_i ( rob_stage_entry ),
        .full_o  ( rob_full        ),
        .empty_o ( rob_empty       ),
        .valid_o ( head_valid      ),
        .entry_o ( head_entry      )
    );

    // Same condition the reorder buffer uses to advance its head
    assign writeback_o = head_valid & !commit_full;
    assign reg_destination_o = head_entry.reg_dest;
    assign writeback_result_o = head_entry.result;

    assign stall_o = commit_full | rob_full;

    // Nothing accepted is still on its way to writeback
    assign pipeline_empty_o = rob_empty & commit_empty & !bypass_valid & !exec_busy &
                              !rob_stage_write;

endmodule : back_end

//--- hdl/back_end_pkg.sv
package back_end_pkg;

    // ==================================================
    // Widths and sizes
    // ==================================================

    // Operand and result width of the integer datapath
    localparam int DATA_WIDTH = 32;

    // Thirty-two architectural registers
    localparam int REG_ADDR_WIDTH = 5;

    // Reorder buffer entries and the tag that indexes them
    localparam int ROB_DEPTH = 8;
    localparam int ROB_TAG_WIDTH = 3;

    // Port 0 is the ALU and port 1 is the multiplier
    localparam int EXU_PORT = 2;

    // Latency of the multiplier pipeline in cycles
    localparam int MUL_STAGES = 3;

    // ==================================================
    // Basic types
    // ==================================================

    typedef logic [DATA_WIDTH - 1:0] data_word_t;
    typedef logic [REG_ADDR_WIDTH - 1:0] reg_addr_t;
    typedef logic [ROB_TAG_WIDTH - 1:0] rob_tag_t;

    // Everything up to SLT runs on the ALU, MUL runs on the multiplier
    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        SLT,
        MUL
    } exu_op_t;

    // ==================================================
    // Bundles
    // ==================================================

    // Destination and tag follow the instruction from issue to commit
    typedef struct packed {
        reg_addr_t reg_dest;
        rob_tag_t tag;
    } instr_packet_t;

    // Output of one execution port
    typedef struct packed {
        logic valid;
        instr_packet_t ipacket;
        data_word_t result;
    } exu_result_t;

    // What a reorder buffer slot holds and what is written back
    typedef struct packed {
        reg_addr_t reg_dest;
        data_word_t result;
    } rob_entry_t;

    // Complete issue bundle from the upstream side
    typedef struct packed {
        exu_op_t op;
        data_word_t [1:0] operand;
        reg_addr_t [1:0] reg_src;
        logic [1:0] immediate_valid;
        instr_packet_t ipacket;
    } issue_t;

endpackage : back_end_pkg

//--- hdl/bypass_controller.sv
`timescale 1ns/100ps

module bypass_controller
    import back_end_pkg::*;
(
    input issue_t issue_i,
    input exu_result_t [EXU_PORT - 1:0] exec_result_i,
    input exu_result_t [EXU_PORT - 1:0] commit_result_i,

    output data_word_t [1:0] operand_o
);

    // Candidates in priority order
    // Execute ports sit at the low indices and commit buffers above them
    exu_result_t [2 * EXU_PORT - 1:0] candidate;

    // One hit bit per source and candidate
    logic [1:0][2 * EXU_PORT - 1:0] hit;

    always_comb begin : candidate_list
        for (int i = 0; i < EXU_PORT; i++) begin
            candidate[i] = exec_result_i[i];
            candidate[EXU_PORT + i] = commit_result_i[i];
        end
    end : candidate_list

    // A source marked immediate never hits so its value stays untouched
    always_comb begin : match_logic
        for (int s = 0; s < 2; s++) begin
            for (int k = 0; k < 2 * EXU_PORT; k++) begin
                hit[s][k] = candidate[k].valid & !issue_i.immediate_valid[s] &
                            (candidate[k].ipacket.reg_dest == issue_i.reg_src[s]);
            end
        end
    end : match_logic

    // Walk from the lowest priority upwards so the last hit wins
    always_comb begin : forward_mux
        for (int s = 0; s < 2; s++) begin
            operand_o[s] = issue_i.operand[s];

            for (int k = 2 * EXU_PORT - 1; k >= 0; k--) begin
                if (hit[s][k]) begin
                    operand_o[s] = candidate[k].result;
                end
            end
        end
    end : forward_mux

    // The ALU and the multiplier never both carry the value a source is waiting for
    // Otherwise the age order between the two ports would decide the operand
    assert final ($countones(hit[0][EXU_PORT - 1:0]) <= 1 &&
                  $countones(hit[1][EXU_PORT - 1:0]) <= 1)
        else $error("Both execute ports forward onto the same source");

endmodule : bypass_controller

//--- hdl/commit_stage.sv
`timescale 1ns/100ps

module commit_stage
    import back_end_pkg::*;
(
    input logic clk_i,
    input logic rst_n_i,
    input logic stall_i,

    input exu_result_t [EXU_PORT - 1:0] result_i,

    output logic full_o,
    output exu_result_t [EXU_PORT - 1:0] buffer_o,

    output logic rob_write_o,
    output rob_tag_t rob_tag_o,
    output rob_entry_t rob_entry_o,

    output logic empty_o
);

    // One result buffer per execution port
    exu_result_t [EXU_PORT - 1:0] buffer_q;

    // One-hot pick of the buffer that goes to the reorder buffer this cycle
    logic [EXU_PORT - 1:0] drain;

    // ==================================================
    // Drain selection
    // ==================================================

    // The highest occupied port wins
    // The multiplier result belongs to the older instruction
    always_comb begin : drain_select
        drain = '0;

        for (int i = 0; i < EXU_PORT; i++) begin
            if (buffer_q[i].valid) begin
                drain = '0;
                drain[i] = 1'b1;
            end
        end
    end : drain_select

    always_comb begin : rob_mux
        rob_write_o = |drain;
        rob_tag_o = '0;
        rob_entry_o = '0;

        for (int i = 0; i < EXU_PORT; i++) begin
            if (drain[i]) begin
                rob_tag_o = buffer_q[i].ipacket.tag;
                rob_entry_o.reg_dest = buffer_q[i].ipacket.reg_dest;
                rob_entry_o.result = buffer_q[i].result;
            end
        end
    end : rob_mux

    // ==================================================
    // Buffers
    // ==================================================

    // Capture follows the execute hold, draining goes on regardless
    always_ff @(posedge clk_i) begin : commit_buffers
        for (int i = 0; i < EXU_PORT; i++) begin
            if (!rst_n_i) begin
                buffer_q[i].valid <= 1'b0;
            end else if (!stall_i && result_i[i].valid) begin
                buffer_q[i] <= result_i[i];
            end else if (drain[i]) begin
                buffer_q[i].valid <= 1'b0;
            end
        end
    end : commit_buffers

    // All buffers busy means no room for another pair of results
    always_comb begin : status
        full_o = 1'b1;
        empty_o = 1'b1;

        for (int i = 0; i < EXU_PORT; i++) begin
            full_o = full_o & buffer_q[i].valid;
            empty_o = empty_o & !buffer_q[i].valid;
        end
    end : status

    assign buffer_o = buffer_q;

    // The stall around the execute stage keeps a held result from being overwritten
    for (genvar i = 0; i < EXU_PORT; i++) begin : g_overwrite_check
        assert property (@(posedge clk_i) disable iff (!rst_n_i)
            !(!stall_i && result_i[i].valid && buffer_q[i].valid && !drain[i]))
            else $error("Commit buffer %0d overwritten while occupied", i);
    end : g_overwrite_check

endmodule : commit_stage

//--- hdl/execution_unit.sv
`timescale 1ns/100ps

module execution_unit
    import back_end_pkg::*;
(
    input logic clk_i,
    input logic rst_n_i,
    input logic stall_i,

    input logic valid_i,
    input exu_op_t op_i,
    input data_word_t [1:0] operand_i,
    input instr_packet_t ipacket_i,

    output exu_result_t [EXU_PORT - 1:0] result_o,
    output logic busy_o
);

    // ==================================================
    // Port 0 ALU
    // ==================================================

    data_word_t alu_result;
    exu_result_t alu_q;

    // Shifts use the low five bits of the second operand
    always_comb begin : alu_logic
        case (op_i)
            ADD: alu_result = operand_i[0] + operand_i[1];
            SUB: alu_result = operand_i[0] - operand_i[1];
            AND: alu_result = operand_i[0] & operand_i[1];
            OR: alu_result = operand_i[0] | operand_i[1];
            XOR: alu_result = operand_i[0] ^ operand_i[1];
            SLL: alu_result = operand_i[0] << operand_i[1][$clog2(DATA_WIDTH) - 1:0];
            SRL: alu_result = operand_i[0] >> operand_i[1][$clog2(DATA_WIDTH) - 1:0];
            SLT: alu_result = {{(DATA_WIDTH - 1){1'b0}},
                               $signed(operand_i[0]) < $signed(operand_i[1])};
            default: alu_result = '0;
        endcase
    end : alu_logic

    always_ff @(posedge clk_i) begin : alu_register
        if (!rst_n_i) begin
            alu_q.valid <= 1'b0;
        end else if (!stall_i) begin
            alu_q.valid <= valid_i & (op_i != MUL);
            alu_q.ipacket <= ipacket_i;
            alu_q.result <= alu_result;
        end
    end : alu_register

    // ==================================================
    // Port 1 multiplier
    // ==================================================

    logic [MUL_STAGES - 1:0] mul_valid;
    instr_packet_t [MUL_STAGES - 1:0] mul_packet;

    // Only the low half of the product is kept
    // Stage 0 forms the 16x16 partial products, stage 1 sums the cross terms
    logic [DATA_WIDTH - 1:0] mul_low, mul_mid, mul_data;
    logic [DATA_WIDTH / 2 - 1:0] mul_cross_a, mul_cross_b, mul_cross;

    always_ff @(posedge clk_i) begin : mul_pipeline
        if (!rst_n_i) begin
            mul_valid <= '0;
        end else if (!stall_i) begin
            mul_valid <= {mul_valid[MUL_STAGES - 2:0], valid_i & (op_i == MUL)};
            mul_packet <= {mul_packet[MUL_STAGES - 2:0], ipacket_i};

            mul_low <= {{(DATA_WIDTH / 2){1'b0}}, operand_i[0][DATA_WIDTH / 2 - 1:0]} *
                       {{(DATA_WIDTH / 2){1'b0}}, operand_i[1][DATA_WIDTH / 2 - 1:0]};
            // Cross products wrap at 16 bits, their upper halves fall out of the word
            mul_cross_a <= operand_i[0][DATA_WIDTH - 1:DATA_WIDTH / 2] *
                           operand_i[1][DATA_WIDTH / 2 - 1:0];
            mul_cross_b <= operand_i[0][DATA_WIDTH / 2 - 1:0] *
                           operand_i[1][DATA_WIDTH - 1:DATA_WIDTH / 2];

            mul_mid <= mul_low;
            mul_cross <= mul_cross_a + mul_cross_b;

            mul_data <= mul_mid + {mul_cross, {(DATA_WIDTH / 2){1'b0}}};
        end
    end : mul_pipeline

    assign result_o[0] = alu_q;
    assign result_o[1] = '{
        valid: mul_valid[MUL_STAGES - 1],
        ipacket: mul_packet[MUL_STAGES - 1],
        result: mul_data
    };

    // Any instruction anywhere in either port
    assign busy_o = alu_q.valid | (|mul_valid);

    // An instruction on the ALU port never also travels through the multiplier
    for (genvar i = 0; i < MUL_STAGES; i++) begin : g_port_check
        assert property (@(posedge clk_i) disable iff (!rst_n_i)
            result_o[0].valid && mul_valid[i] |-> result_o[0].ipacket.tag != mul_packet[i].tag)
            else $error("MUL with tag %0d also present on the ALU port", mul_packet[i].tag);
    end : g_port_check

endmodule : execution_unit

//--- hdl/reorder_buffer.sv
`timescale 1ns/100ps

module reorder_buffer
    import back_end_pkg::*;
(
    input logic clk_i,
    input logic rst_n_i,
    input logic stall_i,

    input logic write_i,
    input rob_tag_t tag_i,
    input rob_entry_t entry_i,

    output logic full_o,
    output logic empty_o,

    output logic valid_o,
    output rob_entry_t entry_o
);

    // Slots are addressed directly by the instruction tag
    rob_entry_t slot_q [ROB_DEPTH];
    logic [ROB_DEPTH - 1:0] slot_valid_q;

    // Tag of the oldest instruction not yet written back
    rob_tag_t head_q;

    // Written but not yet read, one extra bit to reach ROB_DEPTH
    logic [ROB_TAG_WIDTH:0] count_q;

    logic read;

    // ==================================================
    // Head
    // ==================================================

    assign valid_o = slot_valid_q[head_q];
    assign entry_o = slot_q[head_q];

    // The head retires as soon as its own slot has been written
    assign read = valid_o & !stall_i;

    // ==================================================
    // Storage and control
    // ==================================================

    always_ff @(posedge clk_i) begin : slot_storage
        if (write_i) begin
            slot_q[tag_i] <= entry_i;
        end
    end : slot_storage

    always_ff @(posedge clk_i) begin : rob_control
        if (!rst_n_i) begin
            slot_valid_q <= '0;
            head_q <= '0;
            count_q <= '0;
        end else begin
            // Clear before set so a write to the freed head slot stays valid
            if (read) begin
                slot_valid_q[head_q] <= 1'b0;
                head_q <= head_q + 1'b1;
            end

            if (write_i) begin
                slot_valid_q[tag_i] <= 1'b1;
            end

            case ({write_i, read})
                2'b10: count_q <= count_q + 1'b1;
                2'b01: count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end : rob_control

    // Full two entries early
    // Instructions already past issue still find a slot
    assign full_o = count_q >= (ROB_TAG_WIDTH + 1)'(ROB_DEPTH - 2);
    assign empty_o = count_q == '0;

    // Two instructions in flight never share a tag
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        write_i |-> !slot_valid_q[tag_i] || (read && tag_i == head_q))
        else $error("ROB write to occupied slot %0d", tag_i);

endmodule : reorder_buffer

//--- testbench/back_end_golden.txt
// mode idle op src0 imm0 val0 src1 imm1 val1 dest expected, every column in hex
// mode 0 at once 1 after idle cycles 2 after pipeline empty 3 end, op 0 ADD .. 7 SLT 8 MUL
// Constants from immediates
2 0 0 00 1 12345678 00 1 00000000 01 12345678
0 0 0 00 1 fffffff0 00 1 00000005 02 fffffff5
0 0 0 00 1 00000003 00 1 00000000 03 00000003
0 0 1 00 1 00000010 00 1 00000020 04 fffffff0
// Every ALU operation on written-back registers
2 0 0 01 0 00000000 02 0 00000000 05 1234566d
0 0 1 01 0 00000000 03 0 00000000 06 12345675
0 0 2 01 0 00000000 02 0 00000000 07 12345670
0 0 3 01 0 00000000 04 0 00000000 08 fffffff8
0 0 4 01 0 00000000 02 0 00000000 09 edcba98d
0 0 5 01 0 00000000 03 0 00000000 0a 91a2b3c0
0 0 6 02 0 00000000 03 0 00000000 0b 1ffffffe
0 0 7 04 0 00000000 03 0 00000000 0c 00000001
0 0 5 01 0 00000000 00 1 00000024 0e 23456780
// MUL overtaken by younger ALU instructions
2 0 8 01 0 00000000 03 0 00000000 0f 369d0368
0 0 0 03 0 00000000 00 1 00000001 10 00000004
0 0 4 02 0 00000000 04 0 00000000 11 00000005
// Forwarding from the ALU port, commit buffer 0, the MUL port and commit buffer 1
2 0 0 00 1 00000100 00 1 00000023 12 00000123
1 1 0 12 0 00000000 03 0 00000000 13 00000126
1 2 1 13 0 00000000 00 1 00000006 14 00000120
1 1 4 14 0 00000000 12 0 00000000 15 00000003
2 0 8 01 0 00000000 01 0 00000000 16 1df4d840
1 3 0 16 0 00000000 00 1 00000001 17 1df4d841
2 0 8 03 0 00000000 00 1 00000007 18 00000015
1 4 1 18 0 00000000 03 0 00000000 19 00000012
// Back-to-back burst that fills both commit buffers
2 0 8 01 0 00000000 03 0 00000000 1a 369d0368
0 0 8 02 0 00000000 03 0 00000000 1b ffffffdf
0 0 0 01 0 00000000 04 0 00000000 1c 12345668
0 0 1 03 0 00000000 04 0 00000000 1d 00000013
0 0 8 04 0 00000000 04 0 00000000 1e 00000100
0 0 8 01 0 00000000 02 0 00000000 1f 37c048d8
0 0 2 02 0 00000000 04 0 00000000 05 fffffff0
0 0 4 01 0 00000000 12 0 00000000 06 1234575b
0 0 8 03 0 00000000 12 0 00000000 07 00000369
0 0 7 02 0 00000000 03 0 00000000 08 00000001
// Burst results consumed afterwards
2 0 0 1f 0 00000000 1a 0 00000000 09 6e5d4c40
1 2 6 09 0 00000000 00 1 00000004 0a 06e5d4c4
3 0 0 00 0 00000000 00 0 00000000 00 00000000

//--- testbench/back_end_tb.sv
`timescale 1ns/100ps

module back_end_tb
    import back_end_pkg::*;
();

    // ==================================================
    // Constants and signals
    // ==================================================

    localparam int CLK_PERIOD = 100;
    localparam int RESET_CYCLES = 3;

    // Upper bound for any single wait on the DUT
    localparam int WAIT_LIMIT = 200;

    // Each golden record is eleven hex words
    // mode, idle, op, src0, imm0, val0, src1, imm1, val1, dest, expected
    localparam int RECORD_WORDS = 11;
    localparam int GOLDEN_SIZE = RECORD_WORDS * 64;

    // Issue modes of the golden file
    localparam int MODE_AT_ONCE = 0;
    localparam int MODE_IDLE = 1;
    localparam int MODE_EMPTY = 2;
    localparam int MODE_END = 3;

    logic clk;
    logic rst_n;
    logic issue_valid;
    issue_t issue;

    logic stall;
    logic pipeline_empty;
    logic writeback;
    reg_addr_t reg_destination;
    data_word_t writeback_result;

    logic [31:0] golden_mem [0:GOLDEN_SIZE - 1];

    // Architectural register model, only written from the writeback port
    data_word_t reg_file [2 ** REG_ADDR_WIDTH];

    // Destination and result of every accepted instruction in issue order
    reg_addr_t expected_dest_q [$];
    data_word_t expected_result_q [$];

    rob_tag_t next_tag;
    logic stall_seen;

    back_end dut_i (
        .clk_i              ( clk              ),
        .rst_n_i            ( rst_n            ),
        .issue_valid_i      ( issue_valid      ),
        .issue_i            ( issue            ),
        .stall_o            ( stall            ),
        .pipeline_empty_o   ( pipeline_empty   ),
        .writeback_o        ( writeback        ),
        .reg_destination_o  ( reg_destination  ),
        .writeback_result_o ( writeback_result )
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ==================================================
    // Checks
    // ==================================================

    task automatic abort_run();
        $display("Verification failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic compare_dest(input reg_addr_t actual, input reg_addr_t expected);
        if (actual !== expected) begin
            $display("ERR %0t: writeback destination r%0d, expected r%0d",
                     $time, actual, expected);
            abort_run();
        end
    endtask

    task automatic compare_data(input data_word_t actual, input data_word_t expected,
                                input reg_addr_t dest);
        if (actual !== expected) begin
            $display("ERR %0t: result for r%0d is %h, expected %h",
                     $time, dest, actual, expected);
            abort_run();
        end
    endtask

    task automatic compare_flag(input logic actual, input logic expected, input string name);
        if (actual !== expected) begin
            $display("ERR %0t: %s is %b, expected %b", $time, name, actual, expected);
            abort_run();
        end
    endtask

    // ==================================================
    // Cycle handling
    // ==================================================

    // Outputs are sampled on the falling edge where they are stable
    // A writeback retires the oldest queued instruction and updates the model
    task automatic collect_writeback();
        reg_addr_t dest;
        data_word_t result;

        if (stall) begin
            stall_seen = 1'b1;
        end

        if (writeback) begin
            if (expected_dest_q.size() == 0) begin
                $display("Writeback to r%0d with no instruction outstanding", reg_destination);
                abort_run();
            end

            dest = expected_dest_q.pop_front();
            result = expected_result_q.pop_front();
            compare_dest(reg_destination, dest);
            compare_data(writeback_result, result, dest);
            reg_file[reg_destination] = writeback_result;
        end
    endtask

    task automatic next_cycle();
        @(negedge clk);
        collect_writeback();
    endtask

    task automatic wait_pipeline_empty();
        int cycles;

        cycles = 0;
        while (!pipeline_empty) begin
            if (cycles == WAIT_LIMIT) begin
                $display("Timeout while waiting for the pipeline to drain");
                abort_run();
            end
            next_cycle();
            cycles++;
        end
    endtask

    // Idles the issue port as the record's mode asks, then drives the bundle
    // The bundle is held unchanged until a rising edge finds stall low
    task automatic issue_record(input int base);
        issue_t bundle;
        int cycles;
        int mode;

        mode = golden_mem[base];
        issue_valid = 1'b0;

        if (mode == MODE_IDLE) begin
            repeat (golden_mem[base + 1]) next_cycle();
        end else if (mode == MODE_EMPTY) begin
            wait_pipeline_empty();
        end

        bundle = '0;
        bundle.op = exu_op_t'(golden_mem[base + 2][3:0]);

        for (int s = 0; s < 2; s++) begin
            bundle.reg_src[s] = golden_mem[base + 3 + 3 * s][REG_ADDR_WIDTH - 1:0];
            bundle.immediate_valid[s] = golden_mem[base + 4 + 3 * s][0];
            if (bundle.immediate_valid[s]) begin
                bundle.operand[s] = golden_mem[base + 5 + 3 * s];
            end else begin
                bundle.operand[s] = reg_file[bundle.reg_src[s]];
            end
        end

        bundle.ipacket.reg_dest = golden_mem[base + 9][REG_ADDR_WIDTH - 1:0];
        bundle.ipacket.tag = next_tag;

        issue = bundle;
        issue_valid = 1'b1;

        cycles = 0;
        while (stall) begin
            if (cycles == WAIT_LIMIT) begin
                $display("Timeout while waiting for stall_o to release an issue");
                abort_run();
            end
            next_cycle();
            cycles++;
        end

        expected_dest_q.push_back(bundle.ipacket.reg_dest);
        expected_result_q.push_back(golden_mem[base + 10]);
        next_tag = next_tag + 1'b1;

        // The rising edge inside this call accepts the instruction
        next_cycle();
        issue_valid = 1'b0;
    endtask

    // ==================================================
    // Main sequence
    // ==================================================

    initial begin
        int base;

        clk = 1'b0;
        rst_n = 1'b0;
        issue_valid = 1'b0;
        issue = '0;
        next_tag = '0;
        stall_seen = 1'b0;

        for (int r = 0; r < 2 ** REG_ADDR_WIDTH; r++) begin
            reg_file[r] = '0;
        end

        $readmemh("testbench/back_end_golden.txt", golden_mem);
        if (golden_mem[0] === 'x) begin
            $display("Golden file testbench/back_end_golden.txt could not be read");
            abort_run();
        end

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Idle state straight out of reset
        compare_flag(stall, 1'b0, "stall_o");
        compare_flag(writeback, 1'b0, "writeback_o");
        compare_flag(pipeline_empty, 1'b1, "pipeline_empty_o");

        base = 0;
        while (golden_mem[base] !== MODE_END) begin
            if (base + RECORD_WORDS > GOLDEN_SIZE || $isunknown(golden_mem[base]) ||
                golden_mem[base] > MODE_END) begin
                $display("Golden file has a bad record at word %0d", base);
                abort_run();
            end
            issue_record(base);
            base += RECORD_WORDS;
        end

        // Let every outstanding instruction retire
        wait_pipeline_empty();

        if (expected_dest_q.size() != 0 || !stall_seen) begin
            $display("Run ended with %0d instructions not written back, stall seen %b",
                     expected_dest_q.size(), stall_seen);
            abort_run();
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule : back_end_tb
